// File: src/fe_defines.svh
// width and reset constants for the front end, included by the packages, RTL and testbench
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

//////////////////////////////////////////////////
// sample path widths
//////////////////////////////////////////////////

// raw ADC word, two low bits unused on 14-bit parts
`define FE_ADC_IN_W 16
// signed sample and DAC code width
`define FE_SMP_W 14
// gain word, signed fixed point
`define FE_GAIN_W 16
`define FE_GAIN_FRAC 14
// 1.0 in gain units
`define FE_UNITY_GAIN 16384

//////////////////////////////////////////////////
// configuration bus
//////////////////////////////////////////////////

`define FE_AXI_AW 8
`define FE_AXI_DW 32

`endif

// File: src/fe_sample_pkg.sv
// sample path types shared by the channel datapaths and the register block
`include "fe_defines.svh"

package fe_sample_pkg;

  // raw ADC word as it arrives from the pins
  typedef logic [`FE_ADC_IN_W-1:0] adc_raw_t;

  // two's complement sample
  typedef logic signed [`FE_SMP_W-1:0] sample_t;

  // gain, FE_GAIN_FRAC fraction bits
  typedef logic signed [`FE_GAIN_W-1:0] gain_t;

  // offset, added after the gain in sample units
  typedef logic signed [`FE_SMP_W-1:0] offset_t;

  // DAC code, offset binary with inverted slope
  typedef logic [`FE_SMP_W-1:0] dac_code_t;

endpackage

// File: src/fe_reg_pkg.sv
// register map types and byte addresses of the AXI4-Lite calibration block
`include "fe_defines.svh"

package fe_reg_pkg;

  typedef logic [`FE_AXI_AW-1:0] axi_addr_t;
  typedef logic [`FE_AXI_DW-1:0] axi_data_t;
  typedef logic [1:0]            axi_resp_t;

  // loop enables, bit 0 for channel 0, bit 1 for channel 1
  localparam axi_addr_t REG_LOOP      = 8'h00;
  // ADC calibration
  localparam axi_addr_t REG_ADC0_GAIN = 8'h04;
  localparam axi_addr_t REG_ADC0_OFFS = 8'h08;
  localparam axi_addr_t REG_ADC1_GAIN = 8'h0C;
  localparam axi_addr_t REG_ADC1_OFFS = 8'h10;
  // DAC calibration
  localparam axi_addr_t REG_DAC0_GAIN = 8'h14;
  localparam axi_addr_t REG_DAC0_OFFS = 8'h18;
  localparam axi_addr_t REG_DAC1_GAIN = 8'h1C;
  localparam axi_addr_t REG_DAC1_OFFS = 8'h20;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

endpackage

// File: src/calib_regs.sv
// AXI4-Lite slave holding gain, offset and loopback registers for both channel pairs
`timescale 1ns/10ps
`include "fe_defines.svh"

module calib_regs
  import fe_sample_pkg::*;
  import fe_reg_pkg::*;
(
  input  logic      adc_clk,
  input  logic      top_rst,
  // write address and data
  input  axi_addr_t s_awaddr_i,
  input  logic      s_awvalid_i,
  output logic      s_awready_o,
  input  axi_data_t s_wdata_i,
  input  logic      s_wvalid_i,
  output logic      s_wready_o,
  // write response
  output axi_resp_t s_bresp_o,
  output logic      s_bvalid_o,
  input  logic      s_bready_i,
  // read address and data
  input  axi_addr_t s_araddr_i,
  input  logic      s_arvalid_i,
  output logic      s_arready_o,
  output axi_data_t s_rdata_o,
  output axi_resp_t s_rresp_o,
  output logic      s_rvalid_o,
  input  logic      s_rready_i,
  // configuration out
  output logic [1:0] loop_o,
  output gain_t     adc_gain0_o,
  output gain_t     adc_gain1_o,
  output gain_t     dac_gain0_o,
  output gain_t     dac_gain1_o,
  output offset_t   adc_offs0_o,
  output offset_t   adc_offs1_o,
  output offset_t   dac_offs0_o,
  output offset_t   dac_offs1_o
);

  typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
  typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

  wr_state_t wr_state;
  rd_state_t rd_state;
  logic      wr_hs;
  logic      rd_hs;
  axi_data_t rd_val;

  function automatic logic reg_mapped(input axi_addr_t addr);
    case (addr)
      REG_LOOP, REG_ADC0_GAIN, REG_ADC0_OFFS, REG_ADC1_GAIN, REG_ADC1_OFFS,
      REG_DAC0_GAIN, REG_DAC0_OFFS, REG_DAC1_GAIN, REG_DAC1_OFFS: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // write channel
  //////////////////////////////////////////////////

  // address and data accepted together, only when both are offered
  assign wr_hs       = (wr_state == WR_IDLE) && s_awvalid_i && s_wvalid_i;
  assign s_awready_o = wr_hs;
  assign s_wready_o  = wr_hs;
  assign s_bvalid_o  = (wr_state == WR_RESP);

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      wr_state  <= WR_IDLE;
      s_bresp_o <= RESP_OKAY;
    end else begin
      case (wr_state)
        WR_IDLE: begin
          if (wr_hs) begin
            wr_state  <= WR_RESP;
            s_bresp_o <= reg_mapped(s_awaddr_i) ? RESP_OKAY : RESP_SLVERR;
          end
        end
        // hold response until the master takes it
        WR_RESP: begin
          if (s_bready_i) begin
            wr_state <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  // register storage, low bits of the written word
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      loop_o      <= '0;
      adc_gain0_o <= gain_t'(`FE_UNITY_GAIN);
      adc_gain1_o <= gain_t'(`FE_UNITY_GAIN);
      dac_gain0_o <= gain_t'(`FE_UNITY_GAIN);
      dac_gain1_o <= gain_t'(`FE_UNITY_GAIN);
      adc_offs0_o <= '0;
      adc_offs1_o <= '0;
      dac_offs0_o <= '0;
      dac_offs1_o <= '0;
    end else if (wr_hs) begin
      case (s_awaddr_i)
        REG_LOOP:      loop_o      <= s_wdata_i[1:0];
        REG_ADC0_GAIN: adc_gain0_o <= s_wdata_i[`FE_GAIN_W-1:0];
        REG_ADC0_OFFS: adc_offs0_o <= s_wdata_i[`FE_SMP_W-1:0];
        REG_ADC1_GAIN: adc_gain1_o <= s_wdata_i[`FE_GAIN_W-1:0];
        REG_ADC1_OFFS: adc_offs1_o <= s_wdata_i[`FE_SMP_W-1:0];
        REG_DAC0_GAIN: dac_gain0_o <= s_wdata_i[`FE_GAIN_W-1:0];
        REG_DAC0_OFFS: dac_offs0_o <= s_wdata_i[`FE_SMP_W-1:0];
        REG_DAC1_GAIN: dac_gain1_o <= s_wdata_i[`FE_GAIN_W-1:0];
        REG_DAC1_OFFS: dac_offs1_o <= s_wdata_i[`FE_SMP_W-1:0];
        // unmapped, nothing changes
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // read channel
  //////////////////////////////////////////////////

  assign s_arready_o = (rd_state == RD_IDLE) && s_arvalid_i;
  assign rd_hs       = s_arready_o;
  assign s_rvalid_o  = (rd_state == RD_DATA);

  // signed fields sign extend, loop bits are a plain bit field
  always_comb begin
    case (s_araddr_i)
      REG_LOOP:      rd_val = axi_data_t'(loop_o);
      REG_ADC0_GAIN: rd_val = axi_data_t'(adc_gain0_o);
      REG_ADC0_OFFS: rd_val = axi_data_t'(adc_offs0_o);
      REG_ADC1_GAIN: rd_val = axi_data_t'(adc_gain1_o);
      REG_ADC1_OFFS: rd_val = axi_data_t'(adc_offs1_o);
      REG_DAC0_GAIN: rd_val = axi_data_t'(dac_gain0_o);
      REG_DAC0_OFFS: rd_val = axi_data_t'(dac_offs0_o);
      REG_DAC1_GAIN: rd_val = axi_data_t'(dac_gain1_o);
      REG_DAC1_OFFS: rd_val = axi_data_t'(dac_offs1_o);
      default:       rd_val = '0;
    endcase
  end

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      rd_state  <= RD_IDLE;
      s_rdata_o <= '0;
      s_rresp_o <= RESP_OKAY;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (rd_hs) begin
            rd_state  <= RD_DATA;
            s_rdata_o <= rd_val;
            s_rresp_o <= reg_mapped(s_araddr_i) ? RESP_OKAY : RESP_SLVERR;
          end
        end
        RD_DATA: begin
          if (s_rready_i) begin
            rd_state <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

endmodule

// File: src/linear_cal.sv
// two stage gain multiply, offset add and saturate, shared by ADC and DAC channels
`timescale 1ns/10ps
`include "fe_defines.svh"

module linear_cal
  import fe_sample_pkg::*;
(
  input  logic    adc_clk_i,
  input  logic    top_rst_i,
  input  sample_t smp_i,
  input  gain_t   gain_i,
  input  offset_t offs_i,
  output sample_t smp_o
);

  // full product, then drop fraction bits, one guard bit for the add
  localparam int PROD_W = `FE_SMP_W + `FE_GAIN_W;
  localparam int SUM_W  = PROD_W - `FE_GAIN_FRAC + 1;
  localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'(2**(`FE_SMP_W-1) - 1);
  localparam logic signed [SUM_W-1:0] SAT_MIN = -SAT_MAX - 1;

  logic signed [PROD_W-1:0]               prod_q;
  logic signed [PROD_W-`FE_GAIN_FRAC-1:0] prod_sh;
  logic signed [SUM_W-1:0]                sum;
  sample_t                                sat;

  // stage one
  always_ff @(posedge adc_clk_i or posedge top_rst_i) begin
    if (top_rst_i) begin
      prod_q <= '0;
    end else begin
      prod_q <= smp_i * gain_i;
    end
  end

  // taking upper bits is an arithmetic shift, rounds toward minus infinity
  assign prod_sh = prod_q[PROD_W-1:`FE_GAIN_FRAC];
  assign sum     = prod_sh + offs_i;

  // clamp to the sample range
  always_comb begin
    if (sum > SAT_MAX) begin
      sat = sample_t'(SAT_MAX);
    end else if (sum < SAT_MIN) begin
      sat = sample_t'(SAT_MIN);
    end else begin
      sat = sum[`FE_SMP_W-1:0];
    end
  end

  // stage two
  always_ff @(posedge adc_clk_i or posedge top_rst_i) begin
    if (top_rst_i) begin
      smp_o <= '0;
    end else begin
      smp_o <= sat;
    end
  end

endmodule

// File: src/adc_chan.sv
// one ADC channel: raw word capture, loopback select and calibration
`timescale 1ns/10ps

module adc_chan
  import fe_sample_pkg::*;
(
  input  logic     adc_clk_i,
  input  logic     top_rst_i,
  input  adc_raw_t adc_raw_i,
  input  logic     loop_i,
  input  sample_t  loop_smp_i,
  input  gain_t    gain_i,
  input  offset_t  offs_i,
  output sample_t  smp_o
);

  sample_t raw_q;
  sample_t cal_in;

  //////////////////////////////////////////////////
  // capture
  //////////////////////////////////////////////////

  // low two bits unused, MSB kept, rest inverted
  always_ff @(posedge adc_clk_i or posedge top_rst_i) begin
    if (top_rst_i) begin
      raw_q <= '0;
    end else begin
      raw_q <= {adc_raw_i[15], ~adc_raw_i[14:2]};
    end
  end

  // digital loopback replaces the converted sample
  assign cal_in = loop_i ? loop_smp_i : raw_q;

  //////////////////////////////////////////////////
  // calibration
  //////////////////////////////////////////////////

  linear_cal u_cal (
    .adc_clk_i (adc_clk_i),
    .top_rst_i (top_rst_i),
    .smp_i     (cal_in),
    .gain_i    (gain_i),
    .offs_i    (offs_i),
    .smp_o     (smp_o)
  );

endmodule

// File: src/dac_chan.sv
// one generator channel: calibration and conversion to a DAC code
`timescale 1ns/10ps

module dac_chan
  import fe_sample_pkg::*;
(
  input  logic      adc_clk_i,
  input  logic      top_rst_i,
  input  sample_t   gen_smp_i,
  input  gain_t     gain_i,
  input  offset_t   offs_i,
  output sample_t   cal_smp_o,
  output dac_code_t code_o
);

  // calibrated sample, also the loopback source
  linear_cal u_cal (
    .adc_clk_i (adc_clk_i),
    .top_rst_i (top_rst_i),
    .smp_i     (gen_smp_i),
    .gain_i    (gain_i),
    .offs_i    (offs_i),
    .smp_o     (cal_smp_o)
  );

  // signed to offset binary, negative slope
  // MSB kept, the other bits inverted
  assign code_o = {cal_smp_o[13], ~cal_smp_o[12:0]};

endmodule

// File: src/dac_interleave.sv
// merges the two DAC code streams onto a single bus with a channel select line
`timescale 1ns/10ps

module dac_interleave
  import fe_sample_pkg::*;
(
  input  logic      adc_clk_i,
  input  logic      top_rst_i,
  input  dac_code_t code0_i,
  input  dac_code_t code1_i,
  output dac_code_t dac_dat_o,
  output logic      dac_sel_o
);

  // 0 takes channel 0, 1 takes channel 1
  logic phase_q;

  always_ff @(posedge adc_clk_i or posedge top_rst_i) begin
    if (top_rst_i) begin
      phase_q   <= 1'b0;
      dac_dat_o <= '0;
      dac_sel_o <= 1'b0;
    end else begin
      phase_q   <= ~phase_q;
      // select high marks channel 0
      dac_dat_o <= phase_q ? code1_i : code0_i;
      dac_sel_o <= ~phase_q;
    end
  end

endmodule

// File: src/pitaya_fe_top.sv
// front end top: register block, two ADC and two DAC channels and the DAC interleaver
`timescale 1ns/10ps

module pitaya_fe_top
  import fe_sample_pkg::*;
  import fe_reg_pkg::*;
(
  input  logic      adc_clk,
  input  logic      top_rst,
  // converter side
  input  adc_raw_t  adc_dat0_i,
  input  adc_raw_t  adc_dat1_i,
  input  sample_t   gen_dat0_i,
  input  sample_t   gen_dat1_i,
  output sample_t   adc_cal0_o,
  output sample_t   adc_cal1_o,
  output dac_code_t dac_dat_o,
  output logic      dac_sel_o,
  // configuration bus
  input  axi_addr_t s_awaddr_i,
  input  logic      s_awvalid_i,
  output logic      s_awready_o,
  input  axi_data_t s_wdata_i,
  input  logic      s_wvalid_i,
  output logic      s_wready_o,
  output axi_resp_t s_bresp_o,
  output logic      s_bvalid_o,
  input  logic      s_bready_i,
  input  axi_addr_t s_araddr_i,
  input  logic      s_arvalid_i,
  output logic      s_arready_o,
  output axi_data_t s_rdata_o,
  output axi_resp_t s_rresp_o,
  output logic      s_rvalid_o,
  input  logic      s_rready_i
);

  logic [1:0] loop;
  gain_t      adc_gain0, adc_gain1, dac_gain0, dac_gain1;
  offset_t    adc_offs0, adc_offs1, dac_offs0, dac_offs1;
  sample_t    dac_cal0, dac_cal1;
  dac_code_t  dac_code0, dac_code1;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  calib_regs u_regs (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .loop_o      (loop),
    .adc_gain0_o (adc_gain0),
    .adc_gain1_o (adc_gain1),
    .dac_gain0_o (dac_gain0),
    .dac_gain1_o (dac_gain1),
    .adc_offs0_o (adc_offs0),
    .adc_offs1_o (adc_offs1),
    .dac_offs0_o (dac_offs0),
    .dac_offs1_o (dac_offs1)
  );

  //////////////////////////////////////////////////
  // channel 0
  //////////////////////////////////////////////////

  // calibrated generator sample feeds the ADC loopback
  dac_chan u_dac0 (
    .adc_clk_i (adc_clk),
    .top_rst_i (top_rst),
    .gen_smp_i (gen_dat0_i),
    .gain_i    (dac_gain0),
    .offs_i    (dac_offs0),
    .cal_smp_o (dac_cal0),
    .code_o    (dac_code0)
  );

  adc_chan u_adc0 (
    .adc_clk_i  (adc_clk),
    .top_rst_i  (top_rst),
    .adc_raw_i  (adc_dat0_i),
    .loop_i     (loop[0]),
    .loop_smp_i (dac_cal0),
    .gain_i     (adc_gain0),
    .offs_i     (adc_offs0),
    .smp_o      (adc_cal0_o)
  );

  //////////////////////////////////////////////////
  // channel 1
  //////////////////////////////////////////////////

  dac_chan u_dac1 (
    .adc_clk_i (adc_clk),
    .top_rst_i (top_rst),
    .gen_smp_i (gen_dat1_i),
    .gain_i    (dac_gain1),
    .offs_i    (dac_offs1),
    .cal_smp_o (dac_cal1),
    .code_o    (dac_code1)
  );

  adc_chan u_adc1 (
    .adc_clk_i  (adc_clk),
    .top_rst_i  (top_rst),
    .adc_raw_i  (adc_dat1_i),
    .loop_i     (loop[1]),
    .loop_smp_i (dac_cal1),
    .gain_i     (adc_gain1),
    .offs_i     (adc_offs1),
    .smp_o      (adc_cal1_o)
  );

  // single rate stand-in for the DDR output stage
  dac_interleave u_ilv (
    .adc_clk_i (adc_clk),
    .top_rst_i (top_rst),
    .code0_i   (dac_code0),
    .code1_i   (dac_code1),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o)
  );

endmodule

// File: dv/fe_tb_ref.svh
// expected-value models and typed compare tasks, included inside the testbench module
`ifndef FE_TB_REF_SVH
`define FE_TB_REF_SVH

//////////////////////////////////////////////////
// reference models
//////////////////////////////////////////////////

// raw word to signed sample, low two bits dropped, all but the sign flipped
function automatic sample_t ref_adc_conv(input adc_raw_t raw);
  return sample_t'(raw[15:2] ^ 14'h1FFF);
endfunction

// gain, floor toward minus infinity, offset, clamp
function automatic sample_t ref_cal(input sample_t smp, input gain_t gain, input offset_t offs);
  longint prod;
  longint val;
  longint max_v;
  longint min_v;
  max_v = (longint'(1) << (`FE_SMP_W - 1)) - 1;
  min_v = -max_v - 1;
  prod  = longint'(smp) * longint'(gain);
  val   = (prod >>> `FE_GAIN_FRAC) + longint'(offs);
  if (val > max_v) begin
    val = max_v;
  end else if (val < min_v) begin
    val = min_v;
  end
  return sample_t'(val);
endfunction

// code keeps the sign bit, inverts the rest
function automatic dac_code_t ref_dac_code(input sample_t smp);
  return dac_code_t'(smp) ^ 14'h1FFF;
endfunction

// readback of a register slot given the last written word
// slot 0 loop bits, odd slots gains, even slots offsets
function automatic axi_data_t ref_reg_read(input int idx, input axi_data_t wr);
  if (idx == 0) begin
    return {30'b0, wr[1:0]};
  end else if (idx % 2 == 1) begin
    return {{16{wr[15]}}, wr[15:0]};
  end else begin
    return {{18{wr[13]}}, wr[13:0]};
  end
endfunction

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic check_sample(input string name, input sample_t exp, input sample_t act);
  if (act !== exp) begin
    err_sample++;
    $display("Fail %s: expected %0d, actual %0d", name, exp, act);
  end
endtask

task automatic check_code(input string name, input dac_code_t exp, input dac_code_t act);
  if (act !== exp) begin
    err_code++;
    $display("Fail %s: expected 0x%04h, actual 0x%04h", name, exp, act);
  end
endtask

task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
  if (act !== exp) begin
    err_bus++;
    $display("Fail %s: expected resp %0d, actual resp %0d", name, exp, act);
  end
endtask

task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
  if (act !== exp) begin
    err_bus++;
    $display("Fail %s: expected 0x%08h, actual 0x%08h", name, exp, act);
  end
endtask

`endif

// File: dv/fe_tb.sv
// testbench for the front end top: drives AXI4-Lite config and sample streams, checks outputs
`timescale 1ns/10ps
`include "fe_defines.svh"

module fe_tb
  import fe_sample_pkg::*;
  import fe_reg_pkg::*;
();

  localparam int CLK_PERIOD  = 8;
  localparam int SEED        = 62;
  localparam int N_SMP       = 128;
  localparam int N_STREAMS   = 5;
  // reset reads, register test, config writes per stream
  localparam int AXI_OPS     = 9 + 29 + N_STREAMS * 9;
  localparam int AXI_CYCLES  = 6;
  localparam int TEST_CYCLES = N_STREAMS * (N_SMP + 10) + AXI_OPS * AXI_CYCLES + 4;
  localparam int MARGIN      = 500;

  logic      adc_clk;
  logic      top_rst;
  adc_raw_t  adc_dat0_i, adc_dat1_i;
  sample_t   gen_dat0_i, gen_dat1_i;
  sample_t   adc_cal0_o, adc_cal1_o;
  dac_code_t dac_dat_o;
  logic      dac_sel_o;
  axi_addr_t s_awaddr_i, s_araddr_i;
  axi_data_t s_wdata_i, s_rdata_o;
  axi_resp_t s_bresp_o, s_rresp_o;
  logic      s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o;
  logic      s_bvalid_o, s_bready_i, s_arvalid_i, s_arready_o;
  logic      s_rvalid_o, s_rready_i;

  int err_sample = 0;
  int err_code   = 0;
  int err_bus    = 0;
  int err_other  = 0;
  int cyc        = 0;
  string test_name = "reset";
  logic  last_sel  = 1'b0;

  // register slots in map order, with the last written word
  axi_addr_t reg_addr [9];
  axi_data_t shadow [9];

  // current calibration, mirrors what was written to the DUT
  gain_t      cfg_again [2];
  offset_t    cfg_aoffs [2];
  gain_t      cfg_dgain [2];
  offset_t    cfg_doffs [2];
  logic [1:0] cfg_loop;

  // expected values and the cycle each is due
  sample_t   adc0_exp_q [$];
  sample_t   adc1_exp_q [$];
  int        adc0_due_q [$];
  int        adc1_due_q [$];
  dac_code_t dac0_exp_q [$];
  dac_code_t dac1_exp_q [$];
  int        dac_due_q [$];

  `include "fe_tb_ref.svh"

  pitaya_fe_top dut0 (.*);

  //////////////////////////////////////////////////
  // clock, cycle count, watchdog
  //////////////////////////////////////////////////

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  // inputs driven after edge n show up as cyc == n
  always @(posedge adc_clk) begin
    cyc <= cyc + 1;
  end

  initial begin
    #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", TEST_CYCLES + MARGIN);
    $display("errors: sample=%0d code=%0d bus=%0d other=%0d",
             err_sample, err_code, err_bus, err_other);
    $display("TEST FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // comparator, samples mid cycle
  //////////////////////////////////////////////////

  always @(negedge adc_clk) begin
    if (adc0_due_q.size() > 0 && adc0_due_q[0] == cyc) begin
      check_sample({test_name, " adc_cal0"}, adc0_exp_q.pop_front(), adc_cal0_o);
      void'(adc0_due_q.pop_front());
    end
    if (adc1_due_q.size() > 0 && adc1_due_q[0] == cyc) begin
      check_sample({test_name, " adc_cal1"}, adc1_exp_q.pop_front(), adc_cal1_o);
      void'(adc1_due_q.pop_front());
    end
    // select high carries channel 0
    if (dac_due_q.size() > 0 && dac_due_q[0] == cyc) begin
      if (dac_sel_o === last_sel) begin
        err_other++;
        $display("%s: dac_sel_o did not alternate at cycle %0d", test_name, cyc);
      end
      if (dac_sel_o) begin
        check_code({test_name, " dac ch0"}, dac0_exp_q[0], dac_dat_o);
      end else begin
        check_code({test_name, " dac ch1"}, dac1_exp_q[0], dac_dat_o);
      end
      void'(dac0_exp_q.pop_front());
      void'(dac1_exp_q.pop_front());
      void'(dac_due_q.pop_front());
    end
    last_sel = dac_sel_o;
  end

  //////////////////////////////////////////////////
  // AXI4-Lite master
  //////////////////////////////////////////////////

  task automatic axi_write(input axi_addr_t addr, input axi_data_t data, output axi_resp_t resp);
    @(posedge adc_clk);
    #1;
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    // ready seen mid cycle, transfer on the next edge
    do @(negedge adc_clk); while (!(s_awready_o && s_wready_o));
    @(posedge adc_clk);
    #1;
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b1;
    do @(negedge adc_clk); while (!s_bvalid_o);
    resp = s_bresp_o;
    @(posedge adc_clk);
    #1;
    s_bready_i = 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, output axi_data_t data, output axi_resp_t resp);
    @(posedge adc_clk);
    #1;
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    do @(negedge adc_clk); while (!s_arready_o);
    @(posedge adc_clk);
    #1;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b1;
    do @(negedge adc_clk); while (!s_rvalid_o);
    data = s_rdata_o;
    resp = s_rresp_o;
    @(posedge adc_clk);
    #1;
    s_rready_i = 1'b0;
  endtask

  task automatic write_reg(input string name, input axi_addr_t addr, input axi_data_t data,
                           input axi_resp_t exp_resp);
    axi_resp_t resp;
    axi_write(addr, data, resp);
    check_resp(name, exp_resp, resp);
  endtask

  // read one slot back and compare with its shadow
  task automatic read_check(input string name, input int idx);
    axi_data_t data;
    axi_resp_t resp;
    axi_read(reg_addr[idx], data, resp);
    check_resp(name, RESP_OKAY, resp);
    check_data(name, ref_reg_read(idx, shadow[idx]), data);
  endtask

  //////////////////////////////////////////////////
  // calibration setup and sample streams
  //////////////////////////////////////////////////

  task automatic randomize_config(input logic [1:0] loop);
    for (int k = 0; k < 2; k++) begin
      cfg_again[k] = gain_t'($urandom);
      cfg_aoffs[k] = offset_t'($urandom);
      cfg_dgain[k] = gain_t'($urandom);
      cfg_doffs[k] = offset_t'($urandom);
    end
    cfg_loop = loop;
  endtask

  task automatic write_config();
    write_reg("cfg loop", REG_LOOP, axi_data_t'(cfg_loop), RESP_OKAY);
    write_reg("cfg adc0 gain", REG_ADC0_GAIN, axi_data_t'(cfg_again[0]), RESP_OKAY);
    write_reg("cfg adc0 offs", REG_ADC0_OFFS, axi_data_t'(cfg_aoffs[0]), RESP_OKAY);
    write_reg("cfg adc1 gain", REG_ADC1_GAIN, axi_data_t'(cfg_again[1]), RESP_OKAY);
    write_reg("cfg adc1 offs", REG_ADC1_OFFS, axi_data_t'(cfg_aoffs[1]), RESP_OKAY);
    write_reg("cfg dac0 gain", REG_DAC0_GAIN, axi_data_t'(cfg_dgain[0]), RESP_OKAY);
    write_reg("cfg dac0 offs", REG_DAC0_OFFS, axi_data_t'(cfg_doffs[0]), RESP_OKAY);
    write_reg("cfg dac1 gain", REG_DAC1_GAIN, axi_data_t'(cfg_dgain[1]), RESP_OKAY);
    write_reg("cfg dac1 offs", REG_DAC1_OFFS, axi_data_t'(cfg_doffs[1]), RESP_OKAY);
  endtask

  // one random sample per cycle on every input, then wait for the queues to drain
  task automatic run_stream(input string name, input int n);
    adc_raw_t raw [2];
    sample_t  gen [2];
    sample_t  dcal [2];
    sample_t  aexp [2];
    int       adue [2];
    test_name = name;
    for (int i = 0; i < n; i++) begin
      @(posedge adc_clk);
      #1;
      for (int k = 0; k < 2; k++) begin
        raw[k]  = adc_raw_t'($urandom);
        gen[k]  = sample_t'($urandom);
        dcal[k] = ref_cal(gen[k], cfg_dgain[k], cfg_doffs[k]);
        // loopback adds the DAC calibration stage, one cycle more than raw capture
        if (cfg_loop[k]) begin
          aexp[k] = ref_cal(dcal[k], cfg_again[k], cfg_aoffs[k]);
          adue[k] = cyc + 4;
        end else begin
          aexp[k] = ref_cal(ref_adc_conv(raw[k]), cfg_again[k], cfg_aoffs[k]);
          adue[k] = cyc + 3;
        end
      end
      adc_dat0_i = raw[0];
      adc_dat1_i = raw[1];
      gen_dat0_i = gen[0];
      gen_dat1_i = gen[1];
      adc0_exp_q.push_back(aexp[0]);
      adc0_due_q.push_back(adue[0]);
      adc1_exp_q.push_back(aexp[1]);
      adc1_due_q.push_back(adue[1]);
      dac0_exp_q.push_back(ref_dac_code(dcal[0]));
      dac1_exp_q.push_back(ref_dac_code(dcal[1]));
      dac_due_q.push_back(cyc + 3);
    end
    while (adc0_due_q.size() > 0 || adc1_due_q.size() > 0 || dac_due_q.size() > 0) begin
      @(negedge adc_clk);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    axi_data_t data;
    axi_resp_t resp;
    void'($urandom(SEED));
    top_rst     = 1'b1;
    adc_dat0_i  = '0;
    adc_dat1_i  = '0;
    gen_dat0_i  = '0;
    gen_dat1_i  = '0;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    reg_addr = '{REG_LOOP, REG_ADC0_GAIN, REG_ADC0_OFFS, REG_ADC1_GAIN, REG_ADC1_OFFS,
                 REG_DAC0_GAIN, REG_DAC0_OFFS, REG_DAC1_GAIN, REG_DAC1_OFFS};
    repeat (2) @(posedge adc_clk);
    #1;
    top_rst = 1'b0;

    // reset state, still before the first active edge
    check_sample("reset adc_cal0", '0, adc_cal0_o);
    check_sample("reset adc_cal1", '0, adc_cal1_o);
    check_code("reset dac_dat", '0, dac_dat_o);
    if (dac_sel_o !== 1'b0 || s_bvalid_o !== 1'b0 || s_rvalid_o !== 1'b0) begin
      err_other++;
      $display("reset: dac_sel_o or a response valid is not low after reset");
    end
    // gains come up at unity, everything else zero
    for (int i = 0; i < 9; i++) begin
      shadow[i] = (i % 2 == 1) ? axi_data_t'(`FE_UNITY_GAIN) : '0;
      read_check("reset read", i);
    end

    // register access
    test_name = "regs";
    for (int i = 0; i < 9; i++) begin
      shadow[i] = axi_data_t'($urandom);
      write_reg("regs write", reg_addr[i], shadow[i], RESP_OKAY);
    end
    for (int i = 0; i < 9; i++) begin
      read_check("regs read", i);
    end
    write_reg("unmapped write", 8'h40, 32'hFFFF_FFFF, RESP_SLVERR);
    axi_read(8'h40, data, resp);
    check_resp("unmapped read", RESP_SLVERR, resp);
    check_data("unmapped read", '0, data);
    for (int i = 0; i < 9; i++) begin
      read_check("regs after unmapped", i);
    end

    // ADC conditioning, random then near both rails
    randomize_config(2'b00);
    write_config();
    run_stream("adc_random", N_SMP);
    cfg_again = '{gain_t'(16'h7FFF), gain_t'(16'h8000)};
    cfg_aoffs = '{offset_t'(4000), offset_t'(-4000)};
    write_config();
    run_stream("adc_saturate", N_SMP);

    // DAC path and interleave
    randomize_config(2'b00);
    write_config();
    run_stream("dac_random", N_SMP);

    // loopback on one channel at a time
    randomize_config(2'b01);
    write_config();
    run_stream("loop_ch0", N_SMP);
    randomize_config(2'b10);
    write_config();
    run_stream("loop_ch1", N_SMP);

    $display("errors: sample=%0d code=%0d bus=%0d other=%0d",
             err_sample, err_code, err_bus, err_other);
    if (err_sample + err_code + err_bus + err_other == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+src
+incdir+dv
src/fe_sample_pkg.sv
src/fe_reg_pkg.sv
src/calib_regs.sv
src/linear_cal.sv
src/adc_chan.sv
src/dac_chan.sv
src/dac_interleave.sv
src/pitaya_fe_top.sv
dv/fe_tb.sv

// File: Bender.yml
package:
  name: pitaya_fe

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/fe_sample_pkg.sv
      - src/fe_reg_pkg.sv
      - src/calib_regs.sv
      - src/linear_cal.sv
      - src/adc_chan.sv
      - src/dac_chan.sv
      - src/dac_interleave.sv
      - src/pitaya_fe_top.sv
  - target: test
    include_dirs:
      - src
      - dv
    files:
      - dv/fe_tb.sv
